/* hw/codeword_fifo.sv */
`timescale 1ns/10ps

module codeword_fifo #(
    parameter int depth = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  rs_pkg::codeword_t push_word,
    input  logic              pop,
    output logic              word_avail,
    output rs_pkg::codeword_t fifo_word,
    output logic              credit_ret    // one pulse per slot freed
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    rs_pkg::codeword_t mem [depth];    // word storage
    logic [ptr_w-1:0]  wr_ptr;
    logic [ptr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]  count;          // occupancy

    assign word_avail = (count != '0);
    assign fifo_word  = mem[rd_ptr];   // head of queue

    // storage write, no reset on payload
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_word;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end
        else
        begin
            credit_ret <= pop;                     // slot back one cycle after pop
            if (push)   // wrap for non power of two depth
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // both or none
            endcase
        end
    end

endmodule

/* hw/rs_check_combine.sv */
`timescale 1ns/10ps

module rs_check_combine #(
    parameter int out_credits = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic word_avail,
    input  rs_pkg::codeword_t fifo_word,
    input  logic syn_done,
    input  rs_pkg::syndromes_t syndromes,
    input  logic par_done,
    input  logic [rs_pkg::par_sym-1:0] mismatch,
    input  logic out_credit,
    output logic take_word,
    output logic res_valid,
    output rs_pkg::codeword_t res_word,
    output rs_pkg::syndromes_t res_syndromes,
    output logic res_error,
    output logic [rs_pkg::par_sym-1:0] res_mismatch
);

    localparam int cw = $clog2(out_credits + 1);

    logic busy, syn_seen, par_seen, all_done, send;
    logic [cw-1:0] credit_cnt;         // downstream slots left
    rs_pkg::codeword_t word_copy;

    assign take_word = word_avail & ~busy;   // also the calculators' start
    assign all_done  = (syn_seen | syn_done) & (par_seen | par_done);
    assign send      = busy & all_done & (credit_cnt != '0);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy <= 1'b0; // control only
            syn_seen <= 1'b0;
            par_seen <= 1'b0;
            res_valid <= 1'b0;
            credit_cnt <= cw'(out_credits);
        end
        else
        begin
            res_valid  <= send;
            credit_cnt <= credit_cnt - cw'(send) + cw'(out_credit);
            syn_seen   <= ~take_word & ~send & (syn_seen | syn_done);   // clear per word
            par_seen   <= ~take_word & ~send & (par_seen | par_done);
            busy       <= take_word | (busy & ~send);
        end
    end

    // payload, calculator data is stable until the next start
    always_ff @(posedge clk)
    begin
        if (take_word)
            word_copy <= fifo_word;
        if (send)
        begin
            res_word <= word_copy;
            res_syndromes <= syndromes;
            res_error <= |syndromes;          // any nonzero syndrome
            res_mismatch <= mismatch;
        end
    end

endmodule

/* hw/rs_checker_top.sv */
`timescale 1ns/10ps

module rs_checker_top #(
    parameter int in_depth    = 4,
    parameter int out_credits = 2
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // input side, credit based
    input  logic                       in_valid,
    input  rs_pkg::codeword_t          in_word,
    output logic                       in_credit,
    // result side
    output logic                       res_valid,
    output rs_pkg::codeword_t          res_word,
    output rs_pkg::syndromes_t         res_syndromes,
    output logic                       res_error,
    output logic [rs_pkg::par_sym-1:0] res_mismatch,
    input  logic                       out_credit
);

    logic                       word_avail;
    logic                       take_word;    // pop + start + credit
    rs_pkg::codeword_t          fifo_word;
    rs_pkg::syndromes_t         syndromes;
    logic                       syn_done;
    logic [rs_pkg::par_sym-1:0] mismatch;
    logic                       par_done;

    // queue of received words
    codeword_fifo #(
        .depth      (in_depth)
    ) fifo_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (in_valid),
        .push_word  (in_word),
        .pop        (take_word),
        .word_avail (word_avail),
        .fifo_word  (fifo_word),
        .credit_ret (in_credit)
    );

    // six syndromes, 15 cycles
    rs_syndrome_calc syn_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (take_word),
        .word      (fifo_word),
        .syndromes (syndromes),
        .syn_done  (syn_done)
    );

    // re-encode and compare parity, 9 cycles
    rs_parity_calc par_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (take_word),
        .word     (fifo_word),
        .mismatch (mismatch),
        .par_done (par_done)
    );

    rs_check_combine #(
        .out_credits   (out_credits)
    ) comb_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .word_avail    (word_avail),
        .fifo_word     (fifo_word),
        .syn_done      (syn_done),
        .syndromes     (syndromes),
        .par_done      (par_done),
        .mismatch      (mismatch),
        .out_credit    (out_credit),
        .take_word     (take_word),
        .res_valid     (res_valid),
        .res_word      (res_word),
        .res_syndromes (res_syndromes),
        .res_error     (res_error),
        .res_mismatch  (res_mismatch)
    );

endmodule

/* hw/rs_parity_calc.sv */
`timescale 1ns/10ps

module rs_parity_calc (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  rs_pkg::codeword_t          word,
    output logic [rs_pkg::par_sym-1:0] mismatch,
    output logic                       par_done
);

    localparam int sw    = rs_pkg::sym_w;
    localparam int np    = rs_pkg::par_sym;
    localparam int idx_w = $clog2(rs_pkg::k_sym);

    rs_pkg::codeword_t word_q;         // held for the parity compare
    rs_pkg::symbol_t   rem [np];       // division stages, rem[np-1] is x^5
    logic [idx_w-1:0]  sym_idx;        // message symbol being fed
    logic              run;
    rs_pkg::symbol_t   fb;

    // feedback = incoming message symbol + top stage
    assign fb = word_q[sym_idx*sw +: sw] ^ rem[np-1];

    // parity symbol 9+m is the x^(5-m) coefficient
    always_comb
    begin
        for (int m = 0; m < np; m++)
            mismatch[m] = (rem[np-1-m] != word_q[(rs_pkg::k_sym+m)*sw +: sw]);
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            word_q <= word;
            for (int i = 0; i < np; i++)
                rem[i] <= '0;
        end
        else if (run)
        begin
            rem[0] <= rs_pkg::gf_mult(fb, rs_pkg::gen_coef[0]);
            for (int i = 1; i < np; i++)
                rem[i] <= rem[i-1] ^ rs_pkg::gf_mult(fb, rs_pkg::gen_coef[i]);
        end
    end

    // 9 shift cycles then done pulse
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            run      <= 1'b0;
            sym_idx  <= '0;
            par_done <= 1'b0;
        end
        else
        begin
            par_done <= 1'b0;
            if (start)
            begin
                run     <= 1'b1;
                sym_idx <= '0;
            end
            else if (run)
            begin
                sym_idx <= sym_idx + 1'b1;
                if (sym_idx == idx_w'(rs_pkg::k_sym - 1))
                begin
                    run      <= 1'b0;
                    par_done <= 1'b1;
                end
            end
        end
    end

endmodule

/* hw/rs_pkg.sv */
package rs_pkg;

    // RS(15,9) over GF(16), field poly x^4+x+1, alpha = 2
    localparam int sym_w   = 4;
    localparam int n_sym   = 15;
    localparam int k_sym   = 9;
    localparam int par_sym = n_sym - k_sym;     // also number of syndromes
    localparam int code_w  = n_sym * sym_w;

    typedef logic [sym_w-1:0]         symbol_t;
    // symbol i at bits 4i+3:4i, symbol 0 is the x^14 coefficient
    typedef logic [code_w-1:0]        codeword_t;
    // syndrome j at bits 4j+3:4j, value r(alpha^(j+1))
    typedef logic [par_sym*sym_w-1:0] syndromes_t;

    // generator coefficients x^0..x^5 = a^6, a^9, a^6, a^4, a^14, a^10
    localparam symbol_t gen_coef [par_sym] = '{4'd12, 4'd10, 4'd12, 4'd3, 4'd9, 4'd7};

    // roots alpha^1..alpha^6
    localparam symbol_t root_pow [par_sym] = '{4'd2, 4'd4, 4'd8, 4'd3, 4'd6, 4'd12};

    localparam logic [sym_w:0] field_poly = 5'b10011;   // x^4+x+1

    // product of two field elements
    function automatic symbol_t gf_mult(input symbol_t a, input symbol_t b);
        logic [2*sym_w-2:0] prod;
        prod = '0;
        // carry-less multiply
        for (int i = 0; i < sym_w; i++)
        begin
            if (b[i])
                prod = prod ^ ((2*sym_w-1)'(a) << i);
        end
        // reduce from the top bit down
        for (int i = 2*sym_w-2; i >= sym_w; i--)
        begin
            if (prod[i])
                prod = prod ^ ((2*sym_w-1)'(field_poly) << (i - sym_w));
        end
        return prod[sym_w-1:0];
    endfunction

endpackage

/* hw/rs_syndrome_calc.sv */
`timescale 1ns/10ps

module rs_syndrome_calc (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  rs_pkg::codeword_t  word,
    output rs_pkg::syndromes_t syndromes,
    output logic               syn_done
);

    localparam int sw    = rs_pkg::sym_w;
    localparam int cnt_w = $clog2(rs_pkg::n_sym);

    rs_pkg::codeword_t shift_word;     // rotates one symbol per cycle
    logic [cnt_w-1:0]  sym_cnt;        // symbols consumed so far
    logic              run;
    rs_pkg::symbol_t   cur_sym;

    assign cur_sym = shift_word[sw-1:0];   // symbol 0 leaves first

    // Horner step: acc = acc * alpha^(j+1) + symbol, all six in parallel
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            shift_word <= word;
            syndromes  <= '0;
        end
        else if (run)
        begin
            shift_word <= {shift_word[sw-1:0], shift_word[rs_pkg::code_w-1:sw]};
            for (int j = 0; j < rs_pkg::par_sym; j++)
            begin
                syndromes[j*sw +: sw] <= rs_pkg::gf_mult(syndromes[j*sw +: sw],
                                                         rs_pkg::root_pow[j]) ^ cur_sym;
            end
        end
    end

    // pass control, done 15 cycles after start
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            run      <= 1'b0;
            sym_cnt  <= '0;
            syn_done <= 1'b0;
        end
        else
        begin
            syn_done <= 1'b0;
            if (start)
            begin
                run     <= 1'b1;
                sym_cnt <= '0;
            end
            else if (run)
            begin
                sym_cnt <= sym_cnt + 1'b1;
                if (sym_cnt == cnt_w'(rs_pkg::n_sym - 1))   // last symbol
                begin
                    run      <= 1'b0;
                    syn_done <= 1'b1;
                end
            end
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the RS(15,9) checker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f \
    --top-module rs_checker_tb -o rs_checker_sim

./obj_dir/rs_checker_sim > sim.log 2>&1 || true
cat sim.log

# pass only if the testbench printed its pass line
grep -q "^test passed$" sim.log

/* test/rs_checker_props.sv */
`timescale 1ns/10ps

module rs_checker_props #(
    parameter int out_credits = 2,
    parameter int cnt_w       = 2
) (
    input logic             clk,
    input logic             rst_n,
    input logic             res_valid,
    input logic             out_credit,
    input logic             take_word,
    input logic [cnt_w-1:0] credit_cnt
);

    logic [cnt_w-1:0] port_credits;    // credits as seen at the result port
    logic             in_flight;       // word taken, result not out yet

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            port_credits <= cnt_w'(out_credits);
            in_flight    <= 1'b0;
        end
        else
        begin
            port_credits <= port_credits - cnt_w'(res_valid) + cnt_w'(out_credit);
            in_flight    <= take_word | (in_flight & ~res_valid);
        end
    end

    // each result needs a free slot downstream
    res_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> (port_credits != '0))
        else $error("res_valid sent with no output credit");

    credit_cap: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= cnt_w'(out_credits))   // downstream never over-returns
        else $error("output credit count above its limit");

    // next word only once the previous result is out
    no_take_busy: assert property (@(posedge clk) disable iff (!rst_n)
        take_word |-> (!in_flight || res_valid))
        else $error("take_word while a word is in flight");

endmodule

bind rs_check_combine rs_checker_props #(
    .out_credits (out_credits),
    .cnt_w       (cw)
) props_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .res_valid  (res_valid),
    .out_credit (out_credit),
    .take_word  (take_word),
    .credit_cnt (credit_cnt)
);

/* test/rs_checker_tb.sv */
`timescale 1ns/10ps

module rs_checker_tb;

    localparam int fifo_depth = 4;     // default in_depth
    localparam int out_limit  = 2;     // default out_credits

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic in_valid = 1'b0;
    rs_pkg::codeword_t in_word = '0;
    logic out_credit = 1'b0;
    logic in_credit;
    logic res_valid;
    rs_pkg::codeword_t res_word;
    rs_pkg::syndromes_t res_syndromes;
    logic res_error;
    logic [5:0] res_mismatch;

    int seed = 65;
    int check_errors = 0;              // collector side
    int test_errors = 0;               // test task side
    int words_sent = 0;
    int credits_received = 0;          // in_credit pulses seen
    int results_seen = 0;
    int owed = 0;                      // output credits not yet returned
    logic hold_credits = 1'b0;         // stalls out_credit return

    rs_pkg::codeword_t exp_word_q [$];  // expected results, send order
    logic [23:0] exp_syn_q [$];
    logic exp_err_q [$];
    logic [5:0] exp_mis_q [$];

    always #2 clk = ~clk;

    rs_checker_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_word       (in_word),
        .in_credit     (in_credit),
        .res_valid     (res_valid),
        .res_word      (res_word),
        .res_syndromes (res_syndromes),
        .res_error     (res_error),
        .res_mismatch  (res_mismatch),
        .out_credit    (out_credit)
    );

    // shift and add, reduce by x^4+x+1 after each doubling
    function automatic logic [3:0] mul16(input logic [3:0] a, input logic [3:0] b);
        logic [3:0] acc;
        logic [3:0] x;
        acc = 4'd0;
        x = a;
        for (int i = 0; i < 4; i++)
        begin
            if (b[i])
                acc = acc ^ x;
            x = x[3] ? ({x[2:0], 1'b0} ^ 4'b0011) : {x[2:0], 1'b0};
        end
        return acc;
    endfunction

    function automatic logic [3:0] alpha_pow(input int e);
        logic [3:0] p;
        p = 4'd1;
        for (int i = 0; i < e; i++)
            p = mul16(p, 4'd2);
        return p;
    endfunction

    // systematic encode, parity = m(x)*x^6 mod g(x)
    function automatic logic [59:0] make_codeword(input logic [35:0] msg);
        int gen_exp [6] = '{6, 9, 6, 4, 14, 10};   // g0..g5 as alpha powers
        logic [3:0] g [6];
        logic [3:0] r [6];
        logic [3:0] fb;
        logic [59:0] cw;
        for (int k = 0; k < 6; k++)
        begin
            g[k] = alpha_pow(gen_exp[k]);
            r[k] = 4'd0;
        end
        for (int i = 0; i < 9; i++)
        begin
            fb = msg[4*i +: 4] ^ r[5];
            for (int k = 5; k > 0; k--)
                r[k] = r[k-1] ^ mul16(fb, g[k]);
            r[0] = mul16(fb, g[0]);
        end
        cw[35:0] = msg;
        for (int m = 0; m < 6; m++)
            cw[4*(9+m) +: 4] = r[5-m];   // symbol 9 is the x^5 term
        return cw;
    endfunction

    function automatic logic [23:0] model_syndromes(input logic [59:0] w);
        logic [23:0] syn;
        logic [3:0] acc;
        logic [3:0] root;
        syn = '0;
        for (int j = 0; j < 6; j++)
        begin
            root = alpha_pow(j + 1);
            acc = 4'd0;
            for (int i = 0; i < 15; i++)
                acc = mul16(acc, root) ^ w[4*i +: 4];   // x^14 term first
            syn[4*j +: 4] = acc;
        end
        return syn;
    endfunction

    // re-encode message part, compare with received parity
    function automatic logic [5:0] model_mismatch(input logic [59:0] w);
        logic [59:0] ref_cw;
        logic [5:0] mis;
        ref_cw = make_codeword(w[35:0]);
        for (int m = 0; m < 6; m++)
            mis[m] = (ref_cw[4*(9+m) +: 4] != w[4*(9+m) +: 4]);
        return mis;
    endfunction

    function automatic logic [35:0] random_message();
        logic [35:0] msg;
        for (int i = 0; i < 9; i++)
            msg[4*i +: 4] = 4'($random(seed));
        return msg;
    endfunction

    function automatic logic [3:0] random_error();
        logic [3:0] e;
        e = 4'($random(seed));
        return (e == 4'd0) ? 4'd1 : e;   // never zero
    endfunction

    task automatic show_error(input string name, input logic [59:0] got,
                              input logic [59:0] exp);
        $display("Error at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        check_errors++;
    endtask

    // result collector and output credit return
    always @(negedge clk)
    begin
        if (rst_n && res_valid)
        begin
            if (exp_word_q.size() == 0)
            begin
                $display("Error at %0t ns: a result arrived with no word outstanding", $time);
                check_errors++;
            end
            else
            begin
                if (res_word !== exp_word_q[0])
                    show_error("res_word", res_word, exp_word_q[0]);
                if (res_syndromes !== exp_syn_q[0])
                    show_error("res_syndromes", 60'(res_syndromes), 60'(exp_syn_q[0]));
                if (res_error !== exp_err_q[0])
                    show_error("res_error", 60'(res_error), 60'(exp_err_q[0]));
                if (res_mismatch !== exp_mis_q[0])
                    show_error("res_mismatch", 60'(res_mismatch), 60'(exp_mis_q[0]));
                void'(exp_word_q.pop_front());
                void'(exp_syn_q.pop_front());
                void'(exp_err_q.pop_front());
                void'(exp_mis_q.pop_front());
            end
            owed = owed + 1;
            results_seen <= results_seen + 1;
        end
        if (!hold_credits && owed > 0)
        begin
            out_credit <= 1'b1;   // one slot back per cycle
            owed = owed - 1;
        end
        else
            out_credit <= 1'b0;
    end

    always @(negedge clk)
    begin
        if (rst_n && in_credit)
            credits_received <= credits_received + 1;
    end

    task automatic finish_run();
        $display("errors: %0d in results, %0d in other checks, %0d words sent",
                 check_errors, test_errors, words_sent);
        if (check_errors + test_errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    endtask

    task automatic timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        test_errors++;
        finish_run();
    endtask

    // drive one word once a credit is held, stays valid until next negedge
    task automatic send_word(input logic [59:0] w, input logic [23:0] syn,
                             input logic err, input logic [5:0] mis);
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b0;
        while (fifo_depth + credits_received - words_sent <= 0)
        begin
            waited++;
            if (waited > 200)
                timeout("no input credit came back");
            @(negedge clk);
        end
        in_valid = 1'b1;
        in_word = w;
        exp_word_q.push_back(w);
        exp_syn_q.push_back(syn);
        exp_err_q.push_back(err);
        exp_mis_q.push_back(mis);
        words_sent++;
    endtask

    task automatic end_sends();
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (exp_word_q.size() != 0)
        begin
            @(posedge clk);
            waited++;
            if (waited > limit)
                timeout("expected results never arrived");
        end
        repeat (2) @(posedge clk);   // let credits settle
    endtask

    task automatic wait_results(input int target, input int limit);
        int waited;
        waited = 0;
        while (results_seen < target)
        begin
            @(posedge clk);
            waited++;
            if (waited > limit)
                timeout("too few results under back-pressure");
        end
    endtask

    task automatic clean_words();
        logic [59:0] w;
        for (int t = 0; t < 6; t++)
        begin
            w = make_codeword(random_message());
            send_word(w, 24'h0, 1'b0, 6'h0);   // valid codeword, all zero
        end
        end_sends();
        wait_drain(400);
    endtask

    task automatic message_symbol_error();
        logic [59:0] w;
        int pos;
        for (int t = 0; t < 5; t++)
        begin
            w = make_codeword(random_message());
            pos = {$random(seed)} % 9;
            w[4*pos +: 4] = w[4*pos +: 4] ^ random_error();
            send_word(w, model_syndromes(w), 1'b1, model_mismatch(w));
        end
        end_sends();
        wait_drain(400);
    endtask

    task automatic parity_symbol_error();
        logic [59:0] w;
        for (int m = 0; m < 6; m++)
        begin
            w = make_codeword(random_message());
            w[4*(9+m) +: 4] = w[4*(9+m) +: 4] ^ random_error();
            send_word(w, model_syndromes(w), 1'b1, 6'b000001 << m);   // only bit m
        end
        end_sends();
        wait_drain(400);
    endtask

    task automatic output_backpressure();
        int base;
        base = results_seen;
        hold_credits = 1'b1;
        for (int t = 0; t < 6; t++)
            send_word(make_codeword(random_message()), 24'h0, 1'b0, 6'h0);
        end_sends();
        wait_results(base + out_limit, 200);
        repeat (40) @(posedge clk);   // third result must stay back
        if (results_seen != base + out_limit)
        begin
            $display("Error at %0t ns: results_seen got %0d expected %0d",
                     $time, results_seen - base, out_limit);
            test_errors++;
        end
        hold_credits = 1'b0;          // release, collector checks order
        wait_drain(600);
    endtask

    task automatic input_credit_flow();
        int cred_base;
        int sent_base;
        cred_base = credits_received;
        sent_base = words_sent;
        for (int t = 0; t < fifo_depth + 6; t++)   // burst, then credit paced
            send_word(make_codeword(random_message()), 24'h0, 1'b0, 6'h0);
        end_sends();
        wait_drain(800);
        if (credits_received - cred_base != words_sent - sent_base)
        begin
            $display("Error at %0t ns: in_credit pulses got %0d expected %0d",
                     $time, credits_received - cred_base, words_sent - sent_base);
            test_errors++;
        end
    endtask

    initial
    begin
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        clean_words();
        message_symbol_error();
        parity_symbol_error();
        output_backpressure();
        input_credit_flow();
        finish_run();
    end

endmodule

/* vlog.f */
hw/rs_pkg.sv
hw/codeword_fifo.sv
hw/rs_syndrome_calc.sv
hw/rs_parity_calc.sv
hw/rs_check_combine.sv
hw/rs_checker_top.sv
test/rs_checker_props.sv
test/rs_checker_tb.sv
